// File: list.f
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/soc_dev_pkg.sv
verilog/soc_target_if.sv
verilog/bus_decoder.sv
verilog/bus_ram.sv
verilog/sync_fifo.sv
verilog/sys_periph.sv
verilog/soc_top.sv
sim/tb_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC bus testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f list.f --top-module tb_soc -Mdir obj_dir -o vtb_soc > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/vtb_soc > "$SIM_LOG" 2>&1; then
    cat "$SIM_LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: sim/tb_soc.sv
// SoC system bus testbench
// Drives the bus and keyboard ports and checks responses with assertions
`include "soc_defines.svh"
`timescale 1ns/100ps
`default_nettype none

module tb_soc;
    import soc_dev_pkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int RAM_SLOTS   = 8;
    localparam int RUN_LIMIT   = 20000;

    logic        clk;
    logic        reset_i;
    logic        bus_sel_i;
    logic        bus_we_i;
    logic [31:0] bus_addr_i;
    logic [31:0] bus_wdata_i;
    logic [3:0]  bus_wmask_i;
    logic [7:0]  kbd_code_i;
    logic        kbd_strobe_i;
    logic [31:0] bus_rdata_o;
    logic        bus_ack_o;
    logic [7:0]  display_o;
    logic        halted_o;
    logic        addr_valid;

    int value_errors    = 0;
    int protocol_errors = 0;
    int timeout_errors  = 0;

    logic [31:0] ram_model [`SOC_RAM_WORDS];
    int          slot_idx [RAM_SLOTS];
    logic [7:0]  code_queue [$];

    soc_top i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_sel_i    (bus_sel_i),
        .bus_we_i     (bus_we_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .bus_wmask_i  (bus_wmask_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .bus_rdata_o  (bus_rdata_o),
        .bus_ack_o    (bus_ack_o),
        .display_o    (display_o),
        .halted_o     (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Only regions 1 and 2 are mapped
    assign addr_valid = (bus_addr_i[31:28] == 4'h1) || (bus_addr_i[31:28] == 4'h2);

    a_ack_latency: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus_sel_i) && addr_valid && !halted_o |=> bus_ack_o)
        else begin
            protocol_errors++;
            $display("Acknowledge missing one cycle after request at %0t", $time);
        end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        bus_ack_o |=> !bus_ack_o)
        else begin
            protocol_errors++;
            $display("Acknowledge held longer than one cycle at %0t", $time);
        end

    a_halt_on_invalid: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus_sel_i) && !addr_valid |=> halted_o)
        else begin
            protocol_errors++;
            $display("Invalid region access did not halt the bus at %0t", $time);
        end

    a_silent_when_halted: assert property (@(posedge clk) disable iff (reset_i)
        halted_o |-> !bus_ack_o)
        else begin
            protocol_errors++;
            $display("Acknowledge seen while halted at %0t", $time);
        end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        value_errors++;
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
    endtask

    // One request held until acknowledge or timeout
    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wmask,
                              input logic expect_ack, output logic [31:0] rdata);
        int   cycles;
        logic acked;
        @(negedge clk);
        bus_sel_i   = 1'b1;
        bus_we_i    = we;
        bus_addr_i  = addr;
        bus_wdata_i = wdata;
        bus_wmask_i = wmask;
        cycles = 0;
        acked  = 1'b0;
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            acked = bus_ack_o;
        end
        rdata     = bus_rdata_o;
        bus_sel_i = 1'b0;
        bus_we_i  = 1'b0;
        if (expect_ack) begin
            if (!acked) begin
                timeout_errors++;
                $display("No acknowledge within %0d cycles for address 0x%08h",
                         ACK_TIMEOUT, addr);
            end
            assert (!acked || cycles == 1) else begin
                protocol_errors++;
                $display("Access to 0x%08h took %0d cycles", addr, cycles);
            end
        end else begin
            assert (!acked) else begin
                protocol_errors++;
                $display("Unexpected acknowledge for address 0x%08h", addr);
            end
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        logic [31:0] unused_rd;
        bus_access(1'b1, addr, data, mask, 1'b1, unused_rd);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, 4'h0, 1'b1, data);
    endtask

    function automatic logic [31:0] ram_addr(input int idx);
        return 32'h1000_0000 + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] kbd_addr(input logic [11:0] ofs);
        return {4'h2, 12'h000, DEV_KBD, ofs};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    task automatic check_ram(input int idx);
        logic [31:0] rd;
        bus_read(ram_addr(idx), rd);
        assert (rd == ram_model[idx]) else report_value("bus_rdata_o", rd, ram_model[idx]);
    endtask

    task automatic send_code(input logic [7:0] code);
        @(negedge clk);
        kbd_code_i   = code;
        kbd_strobe_i = 1'b1;
        @(negedge clk);
        kbd_strobe_i = 1'b0;
    endtask

    task automatic check_ready(input logic exp);
        logic [31:0] rd;
        bus_read(kbd_addr(KBD_STATUS_OFS), rd);
        assert (rd == {31'h0, exp}) else report_value("bus_rdata_o", rd, {31'h0, exp});
    endtask

    // Dequeue, let the code register settle, then read it
    task automatic pop_code(input logic [7:0] exp);
        logic [31:0] rd;
        bus_write(kbd_addr(KBD_STATUS_OFS), 32'h0, 4'hf);
        repeat (2) @(negedge clk);
        bus_read(kbd_addr(KBD_CODE_OFS), rd);
        assert (rd == {24'h0, exp}) else report_value("bus_rdata_o", rd, {24'h0, exp});
    endtask

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] wd;
        logic [3:0]  mask;
        logic [7:0]  code;
        int          s;
        int          n;
        void'($urandom(32'hdaae_16df));
        reset_i      = 1'b1;
        bus_sel_i    = 1'b0;
        bus_we_i     = 1'b0;
        bus_addr_i   = 32'h0;
        bus_wdata_i  = 32'h0;
        bus_wmask_i  = 4'h0;
        kbd_code_i   = 8'h0;
        kbd_strobe_i = 1'b0;

        apply_reset();
        assert (display_o == 8'h0) else report_value("display_o", {24'h0, display_o}, 32'h0);
        assert (!halted_o) else report_value("halted_o", {31'h0, halted_o}, 32'h0);
        assert (!bus_ack_o) else report_value("bus_ack_o", {31'h0, bus_ack_o}, 32'h0);

        // Every tested word starts from a full zero write
        for (s = 0; s < RAM_SLOTS; s++) begin
            slot_idx[s] = int'($urandom % `SOC_RAM_WORDS);
            bus_write(ram_addr(slot_idx[s]), 32'h0, 4'hf);
            ram_model[slot_idx[s]] = 32'h0;
        end
        for (n = 0; n < 40; n++) begin
            s    = int'($urandom % RAM_SLOTS);
            wd   = $urandom;
            mask = 4'($urandom);
            bus_write(ram_addr(slot_idx[s]), wd, mask);
            ram_model[slot_idx[s]] = merge_bytes(ram_model[slot_idx[s]], wd, mask);
            if (n % 4 == 3)
                check_ram(slot_idx[int'($urandom % RAM_SLOTS)]);
        end
        for (s = 0; s < RAM_SLOTS; s++)
            check_ram(slot_idx[s]);

        // Low byte never matches the reset value of the display
        wd = $urandom | 32'h0000_0001;
        bus_write({4'h2, 12'h000, DEV_DISPLAY, 12'h000}, wd, 4'hf);
        assert (display_o == wd[7:0])
            else report_value("display_o", {24'h0, display_o}, {24'h0, wd[7:0]});
        bus_read(32'h2000_3008, rd);
        assert (rd == 32'h0) else report_value("bus_rdata_o", rd, 32'h0);
        bus_read(kbd_addr(12'h008), rd);
        assert (rd == 32'h0) else report_value("bus_rdata_o", rd, 32'h0);

        for (n = 0; n < 5; n++) begin
            code = 8'($urandom);
            send_code(code);
            code_queue.push_back(code);
        end
        check_ready(1'b1);
        while (code_queue.size() > 0)
            pop_code(code_queue.pop_front());
        check_ready(1'b0);

        // Last two codes land on a full queue
        for (n = 0; n < 34; n++) begin
            code = 8'($urandom);
            send_code(code);
            if (n < 32)
                code_queue.push_back(code);
        end
        check_ready(1'b1);
        while (code_queue.size() > 0)
            pop_code(code_queue.pop_front());
        check_ready(1'b0);

        bus_access(1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b0, rd);
        assert (halted_o) else report_value("halted_o", {31'h0, halted_o}, 32'h1);
        bus_access(1'b0, ram_addr(slot_idx[0]), 32'h0, 4'h0, 1'b0, rd);
        apply_reset();
        assert (!halted_o) else report_value("halted_o", {31'h0, halted_o}, 32'h0);
        check_ram(slot_idx[0]);

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bus_decoder.sv
// Bus region decoder
// Routes requests to RAM or peripherals, halts on unknown regions
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    sel_i,
    input  wire logic                    we_i,
    input  wire soc_bus_pkg::soc_addr_t  addr_i,
    input  wire soc_bus_pkg::soc_data_t  wdata_i,
    input  wire soc_bus_pkg::soc_mask_t  wmask_i,
    output      soc_bus_pkg::soc_data_t  rdata_o,
    output      logic                    ack_o,
    output      logic                    halted_o,
    soc_target_if.decoder                ram_bus,
    soc_target_if.decoder                dev_bus
);
    import soc_bus_pkg::*;

    region_t region;
    logic    region_ok;
    logic    halted_q;

    assign region    = region_t'(addr_i[31:28]);
    assign region_ok = (region == REGION_RAM) || (region == REGION_DEV);

    // Request fan-out, nothing reaches a target once halted
    assign ram_bus.sel   = sel_i && !halted_q && (region == REGION_RAM);
    assign ram_bus.addr  = addr_i;
    assign ram_bus.we    = we_i;
    assign ram_bus.wdata = wdata_i;
    assign ram_bus.wmask = wmask_i;

    assign dev_bus.sel   = sel_i && !halted_q && (region == REGION_DEV);
    assign dev_bus.addr  = addr_i;
    assign dev_bus.we    = we_i;
    assign dev_bus.wdata = wdata_i;
    assign dev_bus.wmask = wmask_i;

    // Return path follows the held address
    assign rdata_o = (region == REGION_RAM) ? ram_bus.rdata : dev_bus.rdata;
    assign ack_o   = ram_bus.ack || dev_bus.ack;

    // Sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            halted_q <= 1'b0;
        end else if (sel_i && !region_ok) begin
            halted_q <= 1'b1;
        end
    end

    assign halted_o = halted_q;

    a_single_target_ack: assert property (@(posedge clk) disable iff (reset_i)
        !(ram_bus.ack && dev_bus.ack));

    a_no_ack_when_halted: assert property (@(posedge clk) disable iff (reset_i)
        halted_q |-> !ack_o);

endmodule

`default_nettype wire

// File: verilog/bus_ram.sv
// On-chip word RAM
// Byte-masked writes, registered reads, acknowledge one cycle after select
`include "soc_defines.svh"
`timescale 1ns/100ps
`default_nettype none

module bus_ram (
    input  wire logic    clk,
    soc_target_if.target bus
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

    soc_data_t        mem [`SOC_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    soc_data_t        rdata_q;

    // Word index sits above the byte offset
    assign idx = bus.addr[IDX_W+1:2];

    // Acknowledge falls on the first edge after it rose, so it idles low
    always_ff @(posedge clk) begin
        ack_q <= bus.sel && !ack_q;
    end

    // Only the first edge of a request touches the array
    always_ff @(posedge clk) begin
        if (bus.sel && !ack_q) begin
            if (bus.we) begin
                for (int b = 0; b < `SOC_MASK_W; b++) begin
                    if (bus.wmask[b])
                        mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    a_index_in_range: assert property (@(posedge clk)
        bus.sel |-> (bus.addr[27:2] < 26'(`SOC_RAM_WORDS)));

endmodule

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
// System bus types
// Address, data and mask words plus the region map of the top nibble
`include "soc_defines.svh"

`default_nettype none

package soc_bus_pkg;

    typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;
    typedef logic [`SOC_DATA_W-1:0] soc_data_t;
    typedef logic [`SOC_MASK_W-1:0] soc_mask_t;

    // Top address nibble, values not listed are invalid
    typedef enum logic [3:0] {
        REGION_RAM = 4'h1,
        REGION_DEV = 4'h2
    } region_t;

endpackage

`default_nettype wire

// File: verilog/soc_defines.svh
// SoC bus build constants
// Bus widths, RAM size and keyboard queue depth
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`default_nettype none

// System bus
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_MASK_W 4

// On-chip RAM depth in 32-bit words
`define SOC_RAM_WORDS 1024

// Keyboard queue holds 2**5 codes
`define KBD_FIFO_ADDR_W 5

`default_nettype wire

`endif

// File: verilog/soc_dev_pkg.sv
// Peripheral map
// Device identifiers, keyboard register offsets and status bits
`default_nettype none

package soc_dev_pkg;

    // Address bits 15:12 inside the device region
    typedef enum logic [3:0] {
        DEV_DISPLAY = 4'h1,
        DEV_KBD     = 4'h5
    } dev_id_t;

    // Byte offsets inside a device window
    localparam logic [11:0] KBD_STATUS_OFS = 12'h000;
    localparam logic [11:0] KBD_CODE_OFS   = 12'h004;

    localparam int KBD_READY_BIT = 0;

    typedef logic [7:0] kbd_code_t;

endpackage

`default_nettype wire

// File: verilog/soc_target_if.sv
// Decoded bus request towards one target
// Request held until the target acknowledges
`timescale 1ns/100ps
`default_nettype none

interface soc_target_if;
    import soc_bus_pkg::*;

    logic      sel;
    soc_addr_t addr;
    logic      we;
    soc_data_t wdata;
    soc_mask_t wmask;
    soc_data_t rdata;
    logic      ack;

    modport decoder (
        output sel, addr, we, wdata, wmask,
        input  rdata, ack
    );

    modport target (
        input  sel, addr, we, wdata, wmask,
        output rdata, ack
    );

endinterface

`default_nettype wire

// File: verilog/soc_top.sv
// SoC system bus top level
// External master port feeding the decoder, RAM and peripheral block
`timescale 1ns/100ps
`default_nettype none

module soc_top (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    bus_sel_i,
    input  wire logic                    bus_we_i,
    input  wire soc_bus_pkg::soc_addr_t  bus_addr_i,
    input  wire soc_bus_pkg::soc_data_t  bus_wdata_i,
    input  wire soc_bus_pkg::soc_mask_t  bus_wmask_i,
    input  wire soc_dev_pkg::kbd_code_t  kbd_code_i,
    input  wire logic                    kbd_strobe_i,
    output      soc_bus_pkg::soc_data_t  bus_rdata_o,
    output      logic                    bus_ack_o,
    output      logic [7:0]              display_o,
    output      logic                    halted_o
);

    // One link per target
    soc_target_if ram_bus ();
    soc_target_if dev_bus ();

    bus_decoder u_decoder (
        .clk      (clk),
        .reset_i  (reset_i),
        .sel_i    (bus_sel_i),
        .we_i     (bus_we_i),
        .addr_i   (bus_addr_i),
        .wdata_i  (bus_wdata_i),
        .wmask_i  (bus_wmask_i),
        .rdata_o  (bus_rdata_o),
        .ack_o    (bus_ack_o),
        .halted_o (halted_o),
        .ram_bus  (ram_bus.decoder),
        .dev_bus  (dev_bus.decoder)
    );

    bus_ram u_ram (
        .clk (clk),
        .bus (ram_bus.target)
    );

    sys_periph u_periph (
        .clk          (clk),
        .reset_i      (reset_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .display_o    (display_o),
        .bus          (dev_bus.target)
    );

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with occupancy count, head word shown combinationally
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int ADDR_W = 4,
    parameter int WIDTH  = 8
) (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic             enq_i,
    input  wire logic             deq_i,
    input  wire logic [WIDTH-1:0] d_i,
    output      logic [WIDTH-1:0] q_o,
    output      logic             empty_o,
    output      logic             full_o
);
    localparam int DEPTH = 1 << ADDR_W;

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W:0]   count;

    always_ff @(posedge clk) begin
        if (enq_i)
            mem[wr_ptr] <= d_i;
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq_i)
                rd_ptr <= rd_ptr + 1'b1;
            if (enq_i && !deq_i)
                count <= count + 1'b1;
            else if (deq_i && !enq_i)
                count <= count - 1'b1;
        end
    end

    assign q_o     = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == (ADDR_W+1)'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        enq_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
        deq_i |-> !empty_o);

endmodule

`default_nettype wire

// File: verilog/sys_periph.sv
// Peripheral block
// Display register and PS/2 keyboard code queue behind the device window
`include "soc_defines.svh"
`timescale 1ns/100ps
`default_nettype none

module sys_periph (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire soc_dev_pkg::kbd_code_t  kbd_code_i,
    input  wire logic                    kbd_strobe_i,
    output      logic [7:0]              display_o,
    soc_target_if.target                 bus
);
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;

    dev_id_t   dev_id;
    logic [11:0] ofs;
    logic      ack_q;
    logic      wr_act;
    logic      kbd_enq;
    logic      kbd_deq;
    logic      fifo_empty;
    logic      fifo_full;
    kbd_code_t fifo_head;
    kbd_code_t code_q;
    soc_data_t rd_word;

    assign dev_id = dev_id_t'(bus.addr[15:12]);
    assign ofs    = bus.addr[11:0];

    // A write acts once, in the cycle before its acknowledge
    assign wr_act = bus.sel && bus.we && !ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.sel && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o <= 8'd0;
        end else if (wr_act && dev_id == DEV_DISPLAY) begin
            display_o <= bus.wdata[7:0];
        end
    end

    // Codes arriving on a full queue are lost
    assign kbd_enq = kbd_strobe_i && !fifo_full;

    // Status write pops the head into the code register
    assign kbd_deq = wr_act && (dev_id == DEV_KBD) && (ofs == KBD_STATUS_OFS) && !fifo_empty;

    sync_fifo #(
        .ADDR_W (`KBD_FIFO_ADDR_W),
        .WIDTH  ($bits(kbd_code_t))
    ) kbd_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .enq_i   (kbd_enq),
        .deq_i   (kbd_deq),
        .d_i     (kbd_code_i),
        .q_o     (fifo_head),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    always_ff @(posedge clk) begin
        if (kbd_deq)
            code_q <= fifo_head;
    end

    // Unmapped registers read as zero
    always_comb begin
        rd_word = '0;
        if (ack_q && dev_id == DEV_KBD) begin
            if (ofs == KBD_STATUS_OFS)
                rd_word[KBD_READY_BIT] = !fifo_empty;
            else if (ofs == KBD_CODE_OFS)
                rd_word = soc_data_t'(code_q);
        end
    end

    assign bus.rdata = rd_word;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire
